//--- Makefile
# Verilator build, run and lint for the Sv32 page-table walker

SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP       := tb_ptw
RTL_TOP   := ptw_top
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Done: no errors
FAIL_MSG  := Done: errors found

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not finish"; exit 1)

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- project.f
+incdir+sim
src/ptw_pkg.sv
src/ptw_pte_check.sv
src/ptw_walk_ctrl.sv
src/ptw_top.sv
sim/tb_ptw.sv

//--- sim/tb_ptw_mem.svh
// ----------------------------------------------------------
// memory model for the walker testbench, included in tb_ptw
// grant after 0..gnt_max cycles, rvalid 1..4 cycles later
// missing table entries read as zero, so they are invalid
// one read in flight at a time, as the walker guarantees
// ----------------------------------------------------------

`ifndef TB_PTW_MEM_SVH
`define TB_PTW_MEM_SVH

// sparse page-table store, keyed by byte address
logic [31:0] pt_mem [paddr_t];
// every address the walker asked for, in order
paddr_t      addr_log [$];
// delay ranges, changed by the tests
int          gnt_max;
int          rv_min;
int          rv_max;
int          mem_errors;

// flags are {d, a, g, u, x, w, r, v}
function automatic ptw_pkg::pte_t make_pte(input logic [21:0] ppn, input logic [7:0] flags);
    return ptw_pkg::pte_t'({ppn, 2'b00, flags});
endfunction

// table base page * 4096 + vpn field * 4
function automatic paddr_t pte_addr(input logic [21:0] base_ppn, input logic [9:0] vpn);
    return (paddr_t'(base_ppn) << 12) + (paddr_t'(vpn) << 2);
endfunction

function automatic void set_pte(input paddr_t addr, input ptw_pkg::pte_t pte);
    pt_mem[addr] = pte;
endfunction

// zero when the walker never issued that read
function automatic paddr_t logged_addr(input int idx);
    if (idx < addr_log.size()) begin
        return addr_log[idx];
    end
    return '0;
endfunction

initial begin : mem_model
    paddr_t      addr;
    int unsigned dly;
    mem_rsp    = '0;
    mem_errors = 0;
    forever begin
        @(posedge clk);
        #1;
        mem_rsp.gnt    = 1'b0;
        mem_rsp.rvalid = 1'b0;
        if (mem_req.req) begin
            addr = mem_req.addr;
            addr_log.push_back(addr);
            dly = $urandom_range(gnt_max, 0);
            // request must stay up with the same address until granted
            repeat (dly) begin
                @(posedge clk);
                #1;
                if (!mem_req.req || mem_req.addr !== addr) begin
                    $display("memory request dropped or moved before grant in test %s",
                             test_name);
                    mem_errors++;
                end
            end
            mem_rsp.gnt = 1'b1;
            dly = $urandom_range(rv_max, rv_min);
            @(posedge clk);
            #1;
            mem_rsp.gnt = 1'b0;
            repeat (dly - 1) begin
                @(posedge clk);
                #1;
            end
            mem_rsp.rvalid = 1'b1;
            mem_rsp.rdata  = pt_mem.exists(addr) ? pt_mem[addr] : '0;
        end
    end
end

`endif

//--- sim/tb_ptw.sv
// ----------------------------------------------------------
// directed testbench for the Sv32 page-table walker
// inputs change 1 ns after the rising edge, outputs are
// sampled on the falling edge
// tables persist across tests, each test uses its own VPNs
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_ptw;

    typedef logic [ptw_pkg::PLEN-1:0] paddr_t;

    // about a dozen walks of up to 40 cycles, with margin
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int RESULT_WAIT    = 100;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      flush;
    ptw_pkg::ptw_req_t         req;
    logic [ptw_pkg::PPN_W-1:0] satp_ppn;
    logic                      mxr;
    ptw_pkg::mem_req_t         mem_req;
    ptw_pkg::mem_rsp_t         mem_rsp;
    ptw_pkg::tlb_update_t      tlb_update;
    logic                      busy;
    logic                      walking_instr;
    logic                      error;
    int                        errors;
    int                        cycles;
    string                     test_name;

    `include "tb_ptw_mem.svh"

    ptw_top u_dut (
        .clk_i           (clk),
        .rst_ni          (rst_n),
        .flush_i         (flush),
        .req_i           (req),
        .satp_ppn_i      (satp_ppn),
        .mxr_i           (mxr),
        .mem_req_o       (mem_req),
        .mem_rsp_i       (mem_rsp),
        .tlb_update_o    (tlb_update),
        .busy_o          (busy),
        .walking_instr_o (walking_instr),
        .error_o         (error)
    );

    // 8 ns period
    always #4 clk = ~clk;

    // ----------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------
    task automatic check_update(input string what, input ptw_pkg::tlb_update_t exp,
                                input ptw_pkg::tlb_update_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(input string what, input paddr_t exp, input paddr_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("CHECK FAILED %s %s: expected %b actual %b", test_name, what, exp, act);
            errors++;
        end
    endtask

    // ----------------------------------------------------------
    // stimulus helpers
    // ----------------------------------------------------------
    function automatic ptw_pkg::tlb_update_t expected_update(input logic [31:0] va,
        input logic [8:0] asid, input logic is_4m, input ptw_pkg::pte_t content);
        ptw_pkg::tlb_update_t u;
        u         = '0;
        u.valid   = 1'b1;
        u.vpn     = va[31:12];
        u.is_4m   = is_4m;
        u.asid    = asid;
        u.content = content;
        return u;
    endfunction

    // one-cycle request once the walker is idle
    task automatic issue_req(input logic [31:0] va, input logic [8:0] asid,
                             input logic is_instr, input logic is_store);
        while (busy) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        req.valid    = 1'b1;
        req.vaddr    = va;
        req.asid     = asid;
        req.is_instr = is_instr;
        req.is_store = is_store;
        @(posedge clk);
        #1;
        req.valid = 1'b0;
    endtask

    // count update and error cycles until the walker is idle again
    task automatic wait_result(output int n_upd, output int n_err,
                               output ptw_pkg::tlb_update_t upd);
        int cyc;
        n_upd = 0;
        n_err = 0;
        upd   = '0;
        cyc   = 0;
        while ((n_upd + n_err == 0 || busy) && cyc < RESULT_WAIT) begin
            @(negedge clk);
            cyc++;
            if (tlb_update.valid) begin
                n_upd++;
                upd = tlb_update;
            end
            if (error) begin
                n_err++;
            end
        end
        if (cyc >= RESULT_WAIT) begin
            $display("walker gave no result within %0d cycles in test %s", RESULT_WAIT,
                     test_name);
            errors++;
        end
    endtask

    task automatic walk(input logic [31:0] va, input logic [8:0] asid, input logic is_instr,
                        input logic is_store, output int n_upd, output int n_err,
                        output ptw_pkg::tlb_update_t upd);
        issue_req(va, asid, is_instr, is_store);
        wait_result(n_upd, n_err, upd);
    endtask

    task automatic expect_fault(input string what, input logic [31:0] va, input logic is_store);
        ptw_pkg::tlb_update_t upd;
        int                   n_upd;
        int                   n_err;
        walk(va, 9'h011, 1'b0, is_store, n_upd, n_err, upd);
        check_bit({what, " error pulse"}, 1'b1, n_err == 1);
        check_bit({what, " no update"}, 1'b1, n_upd == 0);
    endtask

    // ----------------------------------------------------------
    // directed tests
    // ----------------------------------------------------------
    task automatic superpage_load();
        ptw_pkg::pte_t        leaf;
        ptw_pkg::tlb_update_t upd;
        logic [31:0]          va;
        int                   n_upd;
        int                   n_err;
        int                   base;
        test_name = "superpage_load";
        va        = 32'h4050_1234;
        leaf      = make_pte(22'h00C00, 8'b0100_0011);
        set_pte(pte_addr(satp_ppn, va[31:22]), leaf);
        base = addr_log.size();
        walk(va, 9'h05A, 1'b0, 1'b0, n_upd, n_err, upd);
        check_bit("one update", 1'b1, n_upd == 1 && n_err == 0);
        check_update("update", expected_update(va, 9'h05A, 1'b1, leaf), upd);
        check_addr("first read", pte_addr(satp_ppn, va[31:22]), logged_addr(base));
    endtask

    task automatic two_level_fetch();
        ptw_pkg::pte_t        ptr;
        ptw_pkg::pte_t        leaf;
        ptw_pkg::pte_t        exp_leaf;
        ptw_pkg::tlb_update_t upd;
        logic [31:0]          va;
        int                   n_upd;
        int                   n_err;
        int                   base;
        test_name = "two_level_fetch";
        va        = 32'h0804_5678;
        // only the pointer is global
        ptr       = make_pte(22'h00200, 8'b0010_0001);
        leaf      = make_pte(22'h12345, 8'b0100_1001);
        set_pte(pte_addr(satp_ppn, va[31:22]), ptr);
        set_pte(pte_addr(22'h00200, va[21:12]), leaf);
        exp_leaf   = leaf;
        exp_leaf.g = 1'b1;
        base       = addr_log.size();
        issue_req(va, 9'h1C3, 1'b1, 1'b0);
        @(negedge clk);
        check_bit("walking_instr_o", 1'b1, walking_instr);
        wait_result(n_upd, n_err, upd);
        check_bit("one update", 1'b1, n_upd == 1 && n_err == 0);
        check_update("update", expected_update(va, 9'h1C3, 1'b0, exp_leaf), upd);
        check_addr("first read", pte_addr(satp_ppn, va[31:22]), logged_addr(base));
        check_addr("second read", pte_addr(22'h00200, va[21:12]), logged_addr(base + 1));
    endtask

    task automatic fault_cases();
        test_name = "fault_cases";
        // invalid: nothing stored for vpn1 0x300
        expect_fault("invalid", 32'hC000_0000, 1'b0);
        set_pte(pte_addr(satp_ppn, 10'h301), make_pte(22'h00400, 8'b0100_0101));
        expect_fault("write without read", 32'hC040_0000, 1'b0);
        set_pte(pte_addr(satp_ppn, 10'h302), make_pte(22'h00400, 8'b0100_0111));
        expect_fault("store not dirty", 32'hC080_0000, 1'b1);
        set_pte(pte_addr(satp_ppn, 10'h303), make_pte(22'h00401, 8'b1100_0111));
        expect_fault("misaligned superpage", 32'hC0C0_0000, 1'b0);
        // pointer, then another pointer at the last level
        set_pte(pte_addr(satp_ppn, 10'h304), make_pte(22'h00300, 8'b0000_0001));
        set_pte(pte_addr(22'h00300, 10'h007), make_pte(22'h00301, 8'b0000_0001));
        expect_fault("pointer at level 2", 32'hC100_7000, 1'b0);
    endtask

    task automatic mxr_exec_only();
        ptw_pkg::pte_t        leaf;
        ptw_pkg::tlb_update_t upd;
        logic [31:0]          va;
        int                   n_upd;
        int                   n_err;
        test_name = "mxr_exec_only";
        va        = 32'h0400_0ABC;
        leaf      = make_pte(22'h00800, 8'b0100_1001);
        set_pte(pte_addr(satp_ppn, va[31:22]), leaf);
        expect_fault("mxr low", va, 1'b0);
        @(posedge clk);
        #1 mxr = 1'b1;
        walk(va, 9'h033, 1'b0, 1'b0, n_upd, n_err, upd);
        check_bit("one update", 1'b1, n_upd == 1 && n_err == 0);
        check_update("update", expected_update(va, 9'h033, 1'b1, leaf), upd);
        @(posedge clk);
        #1 mxr = 1'b0;
    endtask

    task automatic flush_mid_read();
        ptw_pkg::pte_t        leaf;
        ptw_pkg::tlb_update_t upd;
        logic [31:0]          va;
        logic                 rvalid_seen;
        logic                 busy_at_rvalid;
        int                   n_upd;
        int                   n_err;
        int                   cyc;
        test_name = "flush_mid_read";
        // reuses the superpage from superpage_load
        va        = 32'h4050_1234;
        leaf      = make_pte(22'h00C00, 8'b0100_0011);
        rv_min    = 4;
        rv_max    = 4;
        issue_req(va, 9'h044, 1'b0, 1'b0);
        cyc = 0;
        do begin
            @(negedge clk);
            cyc++;
        end while (!mem_rsp.gnt && cyc < RESULT_WAIT);
        // read granted, rvalid still three cycles away
        @(posedge clk);
        #1 flush = 1'b1;
        @(posedge clk);
        #1 flush = 1'b0;
        n_upd          = 0;
        n_err          = 0;
        rvalid_seen    = 1'b0;
        busy_at_rvalid = 1'b0;
        cyc            = 0;
        while (busy && cyc < RESULT_WAIT) begin
            @(negedge clk);
            cyc++;
            if (tlb_update.valid) begin
                n_upd++;
            end
            if (error) begin
                n_err++;
            end
            if (mem_rsp.rvalid) begin
                rvalid_seen    = 1'b1;
                busy_at_rvalid = busy;
            end
        end
        check_bit("no update", 1'b1, n_upd == 0);
        check_bit("no error", 1'b1, n_err == 0);
        check_bit("late rvalid seen", 1'b1, rvalid_seen);
        check_bit("busy at late rvalid", 1'b1, busy_at_rvalid);
        rv_min = 1;
        rv_max = 4;
        walk(va, 9'h045, 1'b0, 1'b0, n_upd, n_err, upd);
        check_bit("walk after flush", 1'b1, n_upd == 1 && n_err == 0);
        check_update("update after flush", expected_update(va, 9'h045, 1'b1, leaf), upd);
    endtask

    task automatic slow_grant();
        ptw_pkg::pte_t        leaf;
        ptw_pkg::pte_t        exp_leaf;
        ptw_pkg::tlb_update_t upd;
        logic [31:0]          va;
        int                   n_upd;
        int                   n_err;
        int                   base;
        test_name = "slow_grant";
        // level-1 pointer from two_level_fetch, global
        va        = 32'h0804_9000;
        leaf      = make_pte(22'h2A000, 8'b1100_0111);
        set_pte(pte_addr(22'h00200, va[21:12]), leaf);
        exp_leaf   = leaf;
        exp_leaf.g = 1'b1;
        gnt_max    = 12;
        base       = addr_log.size();
        walk(va, 9'h0F0, 1'b0, 1'b1, n_upd, n_err, upd);
        check_bit("one update", 1'b1, n_upd == 1 && n_err == 0);
        check_update("update", expected_update(va, 9'h0F0, 1'b0, exp_leaf), upd);
        check_addr("first read", pte_addr(satp_ppn, va[31:22]), logged_addr(base));
        check_addr("second read", pte_addr(22'h00200, va[21:12]), logged_addr(base + 1));
        gnt_max = 3;
    endtask

    // ----------------------------------------------------------
    // run control
    // ----------------------------------------------------------
    initial begin : watchdog
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    initial begin : main
        void'($urandom(23306));
        errors   = 0;
        rst_n    = 1'b0;
        flush    = 1'b0;
        req      = '0;
        satp_ppn = 22'h00100;
        mxr      = 1'b0;
        gnt_max  = 3;
        rv_min   = 1;
        rv_max   = 4;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        superpage_load();
        two_level_fetch();
        fault_cases();
        mxr_exec_only();
        flush_mid_read();
        slow_grant();
        repeat (4) @(posedge clk);
        $display("errors: %0d in checks, %0d in memory handshake", errors, mem_errors);
        if (errors == 0 && mem_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- src/ptw_pkg.sv
// ----------------------------------------------------------
// shared Sv32 widths, bus structs and enums for the walker
// widths are fixed by Sv32: 32-bit VA, 34-bit PA, 9-bit ASID
// struct field order is part of the interface to the TB
// ----------------------------------------------------------

package ptw_pkg;

    // ----------------------------------------------------------
    // Sv32 widths
    // ----------------------------------------------------------
    localparam int VLEN          = 32;
    localparam int PLEN          = 34;
    localparam int PPN_W         = 22;
    localparam int VPN_W         = 10;
    localparam int ASID_W        = 9;
    localparam int PAGE_OFFSET_W = 12;

    // page-table entry, msb first as laid out in memory
    typedef struct packed {
        logic [PPN_W-1:0] ppn;
        logic [1:0]       rsw;
        logic             d;
        logic             a;
        logic             g;
        logic             u;
        logic             x;
        logic             w;
        logic             r;
        logic             v;
    } pte_t;

    // translation miss from the TLB side
    typedef struct packed {
        logic              valid;
        logic [VLEN-1:0]   vaddr;
        logic [ASID_W-1:0] asid;
        logic              is_instr;
        logic              is_store;
    } ptw_req_t;

    // read request towards memory, word address in bytes
    typedef struct packed {
        logic            req;
        logic [PLEN-1:0] addr;
    } mem_req_t;

    // grant and read data coming back
    typedef struct packed {
        logic        gnt;
        logic        rvalid;
        logic [31:0] rdata;
    } mem_rsp_t;

    // TLB fill, one-cycle pulse on valid
    typedef struct packed {
        logic                          valid;
        logic [VLEN-PAGE_OFFSET_W-1:0] vpn;
        logic                          is_4m;
        logic [ASID_W-1:0]             asid;
        pte_t                          content;
    } tlb_update_t;

    // ----------------------------------------------------------
    // enums
    // ----------------------------------------------------------
    typedef enum logic [1:0] {
        PTE_LEAF_OK,
        PTE_POINTER,
        PTE_FAULT
    } pte_verdict_e;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_GRANT,
        PTE_LOOKUP,
        WAIT_RVALID,
        PROPAGATE_ERROR,
        LATENCY
    } walk_state_e;

    // Sv32 has only two table levels
    typedef enum logic {
        LVL1,
        LVL2
    } walk_lvl_e;

endpackage

//--- src/ptw_pte_check.sv
// ----------------------------------------------------------
// purely combinational PTE classifier, zero latency
// A and D bits are never updated in hardware, a clear bit
// faults so that software can manage them
// clk_i only samples the assertion
// ----------------------------------------------------------

`timescale 1ns/1ps

module ptw_pte_check (
    input  logic                 clk_i,
    input  ptw_pkg::pte_t        pte_i,
    input  ptw_pkg::walk_lvl_e   lvl_i,
    input  logic                 is_instr_i,
    input  logic                 is_store_i,
    input  logic                 mxr_i,
    output ptw_pkg::pte_verdict_e verdict_o
);

    // permission result for a leaf
    logic leaf_ok;

    always_comb begin
        leaf_ok   = 1'b0;
        verdict_o = ptw_pkg::PTE_LEAF_OK;

        // invalid entry or reserved w-without-r encoding
        if (!pte_i.v || (!pte_i.r && pte_i.w)) begin
            verdict_o = ptw_pkg::PTE_FAULT;
        end else if (!pte_i.r && !pte_i.x) begin
            // pointer, only legal above the last level
            if (lvl_i == ptw_pkg::LVL1) begin
                verdict_o = ptw_pkg::PTE_POINTER;
            end else begin
                verdict_o = ptw_pkg::PTE_FAULT;
            end
        end else begin
            // leaf: fetch needs x, data needs r (or x with mxr)
            if (is_instr_i) begin
                leaf_ok = pte_i.x && pte_i.a;
            end else begin
                leaf_ok = pte_i.a && (pte_i.r || (pte_i.x && mxr_i));
            end
            // stores additionally need a writable, dirty page
            if (is_store_i && !(pte_i.w && pte_i.d)) begin
                leaf_ok = 1'b0;
            end
            // 4 MiB superpage must have ppn[0] field zero
            if (lvl_i == ptw_pkg::LVL1 && pte_i.ppn[ptw_pkg::VPN_W-1:0] != '0) begin
                leaf_ok = 1'b0;
            end
            verdict_o = leaf_ok ? ptw_pkg::PTE_LEAF_OK : ptw_pkg::PTE_FAULT;
        end
    end

    // ----------------------------------------------------------
    // assertions
    // ----------------------------------------------------------
    // the controller never descends below level 2
    a_no_ptr_at_lvl2 : assert property (
        @(posedge clk_i) (lvl_i == ptw_pkg::LVL2) |-> (verdict_o != ptw_pkg::PTE_POINTER)
    ) else $error("pointer verdict at last level");

endmodule

//--- src/ptw_top.sv
// ----------------------------------------------------------
// Sv32 page-table walker top: FSM plus PTE checker
// one walk at a time, wait for busy_o low before requesting
// no back-pressure on tlb_update_o or error_o
// ----------------------------------------------------------

`timescale 1ns/1ps

module ptw_top (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      flush_i,
    input  ptw_pkg::ptw_req_t         req_i,
    input  logic [ptw_pkg::PPN_W-1:0] satp_ppn_i,
    input  logic                      mxr_i,
    output ptw_pkg::mem_req_t         mem_req_o,
    input  ptw_pkg::mem_rsp_t         mem_rsp_i,
    output ptw_pkg::tlb_update_t      tlb_update_o,
    output logic                      busy_o,
    output logic                      walking_instr_o,
    output logic                      error_o
);

    // controller to checker
    ptw_pkg::pte_t         pte;
    ptw_pkg::walk_lvl_e    lvl;
    logic                  is_instr;
    logic                  is_store;
    ptw_pkg::pte_verdict_e verdict;

    ptw_walk_ctrl u_walk_ctrl (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .req_i           (req_i),
        .satp_ppn_i      (satp_ppn_i),
        .mem_req_o       (mem_req_o),
        .mem_rsp_i       (mem_rsp_i),
        .tlb_update_o    (tlb_update_o),
        .busy_o          (busy_o),
        .walking_instr_o (walking_instr_o),
        .error_o         (error_o),
        .pte_o           (pte),
        .lvl_o           (lvl),
        .is_instr_o      (is_instr),
        .is_store_o      (is_store),
        .verdict_i       (verdict)
    );

    ptw_pte_check u_pte_check (
        .clk_i      (clk_i),
        .pte_i      (pte),
        .lvl_i      (lvl),
        .is_instr_i (is_instr),
        .is_store_i (is_store),
        .mxr_i      (mxr_i),
        .verdict_o  (verdict)
    );

endmodule

//--- src/ptw_walk_ctrl.sv
// ----------------------------------------------------------
// Sv32 walk FSM with req/gnt/rvalid memory port
// one read outstanding at most; read data is registered, so
// the verdict acts one cycle after rvalid
// flush with a read in flight drains the rvalid first
// requests arriving while busy_o is high are dropped
// ----------------------------------------------------------

`timescale 1ns/1ps

module ptw_walk_ctrl (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        flush_i,
    input  ptw_pkg::ptw_req_t           req_i,
    input  logic [ptw_pkg::PPN_W-1:0]   satp_ppn_i,
    output ptw_pkg::mem_req_t           mem_req_o,
    input  ptw_pkg::mem_rsp_t           mem_rsp_i,
    output ptw_pkg::tlb_update_t        tlb_update_o,
    output logic                        busy_o,
    output logic                        walking_instr_o,
    output logic                        error_o,
    output ptw_pkg::pte_t               pte_o,
    output ptw_pkg::walk_lvl_e          lvl_o,
    output logic                        is_instr_o,
    output logic                        is_store_o,
    input  ptw_pkg::pte_verdict_e       verdict_i
);

    ptw_pkg::walk_state_e state_q, state_d;
    ptw_pkg::walk_lvl_e   lvl_q, lvl_d;

    // walk context latched at the request
    logic [ptw_pkg::VLEN-1:0]   vaddr_q, vaddr_d;
    logic [ptw_pkg::ASID_W-1:0] asid_q, asid_d;
    logic                       is_instr_q, is_instr_d;
    logic                       is_store_q, is_store_d;
    // sticky global bit over all fetched entries
    logic                       global_q, global_d;
    // byte address of the PTE being read
    logic [ptw_pkg::PLEN-1:0]   pptr_q, pptr_d;

    // registered memory response
    logic                       rvalid_q;
    logic [31:0]                rdata_q;
    ptw_pkg::pte_t              pte;

    assign pte = ptw_pkg::pte_t'(rdata_q);

    // to the checker
    assign pte_o      = pte;
    assign lvl_o      = lvl_q;
    assign is_instr_o = is_instr_q;
    assign is_store_o = is_store_q;

    assign busy_o          = (state_q != ptw_pkg::IDLE);
    assign walking_instr_o = is_instr_q;
    assign error_o         = (state_q == ptw_pkg::PROPAGATE_ERROR);

    assign mem_req_o.req  = (state_q == ptw_pkg::WAIT_GRANT);
    assign mem_req_o.addr = pptr_q;

    // ----------------------------------------------------------
    // next-state logic
    // ----------------------------------------------------------
    always_comb begin
        state_d    = state_q;
        lvl_d      = lvl_q;
        vaddr_d    = vaddr_q;
        asid_d     = asid_q;
        is_instr_d = is_instr_q;
        is_store_d = is_store_q;
        global_d   = global_q;
        pptr_d     = pptr_q;

        tlb_update_o.valid     = 1'b0;
        tlb_update_o.vpn       = vaddr_q[ptw_pkg::VLEN-1:ptw_pkg::PAGE_OFFSET_W];
        tlb_update_o.is_4m     = (lvl_q == ptw_pkg::LVL1);
        tlb_update_o.asid      = asid_q;
        // g is inherited from any level of the walk
        tlb_update_o.content   = pte;
        tlb_update_o.content.g = pte.g | global_q;

        unique case (state_q)
            ptw_pkg::IDLE: begin
                lvl_d      = ptw_pkg::LVL1;
                global_d   = 1'b0;
                is_instr_d = 1'b0;
                is_store_d = 1'b0;
                if (req_i.valid) begin
                    // satp.ppn * 4096 + vpn[1] * 4
                    pptr_d     = {satp_ppn_i, req_i.vaddr[31:22], 2'b00};
                    vaddr_d    = req_i.vaddr;
                    asid_d     = req_i.asid;
                    is_instr_d = req_i.is_instr;
                    is_store_d = req_i.is_store;
                    state_d    = ptw_pkg::WAIT_GRANT;
                end
            end
            ptw_pkg::WAIT_GRANT: begin
                if (mem_rsp_i.gnt) begin
                    state_d = ptw_pkg::PTE_LOOKUP;
                end
            end
            ptw_pkg::PTE_LOOKUP: begin
                if (rvalid_q) begin
                    global_d = global_q | pte.g;
                    unique case (verdict_i)
                        ptw_pkg::PTE_LEAF_OK: begin
                            // dropped if a flush hits this cycle
                            tlb_update_o.valid = !flush_i;
                            state_d            = ptw_pkg::LATENCY;
                        end
                        ptw_pkg::PTE_POINTER: begin
                            // pte.ppn * 4096 + vpn[0] * 4
                            lvl_d   = ptw_pkg::LVL2;
                            pptr_d  = {pte.ppn, vaddr_q[21:12], 2'b00};
                            state_d = ptw_pkg::WAIT_GRANT;
                        end
                        default: begin
                            state_d = ptw_pkg::PROPAGATE_ERROR;
                        end
                    endcase
                end
            end
            ptw_pkg::PROPAGATE_ERROR: begin
                state_d = ptw_pkg::LATENCY;
            end
            ptw_pkg::WAIT_RVALID: begin
                // drain the read left over from a flushed walk
                if (rvalid_q) begin
                    state_d = ptw_pkg::IDLE;
                end
            end
            ptw_pkg::LATENCY: begin
                state_d = ptw_pkg::IDLE;
            end
            default: begin
                state_d = ptw_pkg::IDLE;
            end
        endcase

        // ------------------------------------------------------
        // flush
        // ------------------------------------------------------
        // a granted read whose rvalid is still to come must be absorbed
        if (flush_i) begin
            if (((state_q inside {ptw_pkg::PTE_LOOKUP, ptw_pkg::WAIT_RVALID}) && !rvalid_q) ||
                ((state_q == ptw_pkg::WAIT_GRANT) && mem_rsp_i.gnt)) begin
                state_d = ptw_pkg::WAIT_RVALID;
            end else begin
                state_d = ptw_pkg::LATENCY;
            end
        end
    end

    // ----------------------------------------------------------
    // registers
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= ptw_pkg::IDLE;
            lvl_q      <= ptw_pkg::LVL1;
            is_instr_q <= 1'b0;
            is_store_q <= 1'b0;
            global_q   <= 1'b0;
            rvalid_q   <= 1'b0;
            vaddr_q    <= '0;
            asid_q     <= '0;
            pptr_q     <= '0;
            rdata_q    <= '0;
        end else begin
            state_q    <= state_d;
            lvl_q      <= lvl_d;
            is_instr_q <= is_instr_d;
            is_store_q <= is_store_d;
            global_q   <= global_d;
            rvalid_q   <= mem_rsp_i.rvalid;
            vaddr_q    <= vaddr_d;
            asid_q     <= asid_d;
            pptr_q     <= pptr_d;
            rdata_q    <= mem_rsp_i.rdata;
        end
    end

    // ----------------------------------------------------------
    // assertions
    // ----------------------------------------------------------
    // request held stable until granted unless flushed
    a_req_stable : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (mem_req_o.req && !mem_rsp_i.gnt && !flush_i) |=>
            (mem_req_o.req && $stable(mem_req_o.addr))
    ) else $error("memory request changed before grant");

    // a walk ends in exactly one way
    a_update_xor_error : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !(tlb_update_o.valid && error_o)
    ) else $error("update and error in the same cycle");

endmodule
